//--- src/coproc_pkg.sv
// package: datapath widths, pipeline depth, reset pulse widths, uptime width, pulse state enum
package coproc_pkg;

  // ========================================
  // multiplier datapath
  // ========================================
  parameter int operand_w   = 16;   // one unsigned operand
  parameter int word_w      = 32;   // fifo word, also product width
  parameter int mult_stages = 3;    // default pipeline depth

  // ========================================
  // reset request pulse widths, in cycles
  // ========================================
  parameter int cold_pulse_ext  = 6;
  parameter int warm_pulse_ext  = 2;
  parameter int debug_pulse_ext = 32;

  // ========================================
  // status
  // ========================================
  parameter int uptime_w = 32;   // free-running counter
  parameter int led_w    = 10;   // red leds, top bits of counter

  // pulse channel state
  typedef enum logic {
    pulse_idle   = 1'b0,
    pulse_active = 1'b1   // pulse output high
  } pulse_state_t;

endpackage

//--- src/pulse_timer.sv
// module pulse_timer: loadable down-counter flagging the end of one pulse interval
module pulse_timer import coproc_pkg::*; #(
  parameter int pulse_ext = cold_pulse_ext   // interval length in cycles
) (
  input  logic CLOCK_50,
  input  logic hps_fpga_reset_n,
  input  logic load,      // restart the interval
  output logic expired    // interval over
);

  // counter holds at most pulse_ext-1, keep at least one bit
  localparam int cnt_w = (pulse_ext > 1) ? $clog2(pulse_ext) : 1;
  localparam logic [cnt_w-1:0] load_val = cnt_w'(pulse_ext - 1);

  logic [cnt_w-1:0] cnt_q;

  // ========================================
  // down-counter
  // ========================================
  always_ff @(posedge CLOCK_50 or negedge hps_fpga_reset_n) begin
    if (!hps_fpga_reset_n) begin
      cnt_q <= '0;
    end else if (load) begin
      cnt_q <= load_val;               // first cycle of pulse counts as one
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;           // stops at zero
    end
  end

  // last cycle of the interval is the one that reads zero
  // a load in the same cycle restarts, so no expiry then
  assign expired = (cnt_q == '0) && !load;

endmodule

//--- src/reset_req_fsm.sv
// module reset_req_fsm: rising edge detector and pulse state machine for one reset request line
module reset_req_fsm import coproc_pkg::*; #(
  parameter int pulse_ext = cold_pulse_ext   // pulse width in cycles
) (
  input  logic CLOCK_50,
  input  logic hps_fpga_reset_n,
  input  logic req,      // raw request level
  output logic pulse     // active high reset request pulse
);

  logic         req_q;      // registered request
  logic         req_prev;   // one cycle older, for edge compare
  logic         rise;
  logic         load;       // start the timer
  logic         expired;    // timer done
  pulse_state_t state_q;
  pulse_state_t state_d;

  // ========================================
  // edge detect
  // ========================================
  always_ff @(posedge CLOCK_50 or negedge hps_fpga_reset_n) begin
    if (!hps_fpga_reset_n) begin
      req_q    <= 1'b0;
      req_prev <= 1'b0;
    end else begin
      req_q    <= req;       // request lands here on first edge
      req_prev <= req_q;
    end
  end

  assign rise = req_q && !req_prev;   // low to high only

  // ========================================
  // pulse state machine
  // ========================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      pulse_idle: begin
        if (rise) state_d = pulse_active;
      end
      pulse_active: begin
        // further edges dropped here
        if (expired) state_d = pulse_idle;
      end
      default: state_d = pulse_idle;
    endcase
  end

  always_ff @(posedge CLOCK_50 or negedge hps_fpga_reset_n) begin
    if (!hps_fpga_reset_n) begin
      state_q <= pulse_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // timer restarts on the edge that enters active
  assign load  = (state_q == pulse_idle) && rise;
  assign pulse = (state_q == pulse_active);

  pulse_timer #(
    .pulse_ext (pulse_ext)
  ) timer_inst (
    .CLOCK_50         (CLOCK_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .load             (load),
    .expired          (expired)
  );

endmodule

//--- src/mult_pipe.sv
// module mult_pipe: operand unpacking and stallable unsigned multiply pipeline between fifo ports
module mult_pipe import coproc_pkg::*; #(
  parameter int stages = mult_stages   // product registers, also latency
) (
  input  logic              CLOCK_50,
  input  logic              hps_fpga_reset_n,

  // host to fpga fifo
  input  logic [word_w-1:0] in_readdata,
  input  logic              in_waitrequest,
  output logic              in_read,

  // fpga to host fifo
  output logic [word_w-1:0] out_writedata,
  output logic              out_write,
  input  logic              out_waitrequest
);

  logic [operand_w-1:0] op_a;
  logic [operand_w-1:0] op_b;
  logic [word_w-1:0]    prod_d;           // full width product
  logic                 stall;
  logic [word_w-1:0]    prod_q [stages];  // product per stage
  logic [stages-1:0]    vld_q;            // valid per stage

  // ========================================
  // unpack and multiply
  // ========================================
  assign op_a = in_readdata[operand_w-1:0];        // low half
  assign op_b = in_readdata[word_w-1:operand_w];   // high half

  // 16x16 unsigned fits the 32 bit word exactly
  assign prod_d = op_a * op_b;

  // ========================================
  // flow control
  // ========================================
  // host side holds the head word while out_waitrequest is high,
  // so the whole pipe freezes, bubbles included
  assign stall = out_waitrequest;

  // pop a word only when fifo has one and pipe can move
  assign in_read = !in_waitrequest && !stall;

  // ========================================
  // pipeline registers
  // ========================================
  always_ff @(posedge CLOCK_50 or negedge hps_fpga_reset_n) begin
    if (!hps_fpga_reset_n) begin
      vld_q <= '0;
    end else if (!stall) begin
      vld_q[0] <= in_read;   // taken word enters stage 0
      for (int i = 1; i < stages; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  // payload, follows the valid bits
  always_ff @(posedge CLOCK_50) begin
    if (!stall) begin
      if (in_read) begin
        prod_q[0] <= prod_d;   // skip toggling on bubbles
      end
      for (int i = 1; i < stages; i++) begin
        prod_q[i] <= prod_q[i-1];
      end
    end
  end

  // ========================================
  // output port
  // ========================================
  // last stage drives the fifo directly; during stall
  // both hold since nothing shifts
  assign out_write     = vld_q[stages-1];
  assign out_writedata = prod_q[stages-1];

endmodule

//--- src/coproc_top.sv
// module coproc_top: multiply pipeline, three reset request channels, uptime counter and leds
module coproc_top import coproc_pkg::*; (
  input  logic                CLOCK_50,
  input  logic                hps_fpga_reset_n,

  // host to fpga fifo, operands in
  input  logic [word_w-1:0]   in_readdata,
  input  logic                in_waitrequest,
  output logic                in_read,

  // fpga to host fifo, products out
  output logic [word_w-1:0]   out_writedata,
  output logic                out_write,
  input  logic                out_waitrequest,

  // reset requests, bit 0 cold, 1 warm, 2 debug
  input  logic [2:0]          reset_req,
  output logic                cold_reset,
  output logic                warm_reset,
  output logic                debug_reset,

  // status
  output logic [uptime_w-1:0] status_count,
  output logic [led_w-1:0]    ledr
);

  logic [uptime_w-1:0] uptime_q;   // free-running cycle count

  // ========================================
  // product coprocessor
  // ========================================
  mult_pipe #(
    .stages (mult_stages)
  ) mult_inst (
    .CLOCK_50         (CLOCK_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .in_readdata      (in_readdata),
    .in_waitrequest   (in_waitrequest),
    .in_read          (in_read),
    .out_writedata    (out_writedata),
    .out_write        (out_write),
    .out_waitrequest  (out_waitrequest)
  );

  // ========================================
  // reset request channels
  // ========================================
  // cold, short pulse
  reset_req_fsm #(
    .pulse_ext (cold_pulse_ext)
  ) cold_req_inst (
    .CLOCK_50         (CLOCK_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req              (reset_req[0]),
    .pulse            (cold_reset)
  );

  // warm, shortest
  reset_req_fsm #(
    .pulse_ext (warm_pulse_ext)
  ) warm_req_inst (
    .CLOCK_50         (CLOCK_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req              (reset_req[1]),
    .pulse            (warm_reset)
  );

  // debug, long pulse
  reset_req_fsm #(
    .pulse_ext (debug_pulse_ext)
  ) debug_req_inst (
    .CLOCK_50         (CLOCK_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req              (reset_req[2]),
    .pulse            (debug_reset)
  );

  // ========================================
  // uptime counter
  // ========================================
  always_ff @(posedge CLOCK_50 or negedge hps_fpga_reset_n) begin
    if (!hps_fpga_reset_n) begin
      uptime_q <= '0;
    end else begin
      uptime_q <= uptime_q + 1'b1;   // wraps after 2^32 cycles
    end
  end

  assign status_count = uptime_q;                       // status word for host
  assign ledr         = uptime_q[uptime_w-1 -: led_w];  // slow bits, visible blink

endmodule

//--- tests/coproc_tb.sv
// testbench: clock, reset, directed tests, product scoreboard, timeout and summary
module coproc_tb;

  localparam int latency        = 3;      // accept edge to delivery edge, no stall
  localparam int timeout_cycles = 5000;   // tests need roughly 2000 edges

  logic        CLOCK_50 = 1'b0;
  logic        hps_fpga_reset_n;
  logic [31:0] in_readdata;
  logic        in_waitrequest;
  logic        in_read;
  logic [31:0] out_writedata;
  logic        out_write;
  logic        out_waitrequest;
  logic [2:0]  reset_req;
  logic        cold_reset;
  logic        warm_reset;
  logic        debug_reset;
  logic [31:0] status_count;
  logic [9:0]  ledr;

  int          cyc = 0;           // edges seen, nba updated
  int          stall_total = 0;   // edges with out_waitrequest high
  int          accepted = 0;
  int          delivered = 0;
  int          rel_cyc = 0;       // cyc at first edge after reset release
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  logic [31:0] exp_q [$];         // expected products, in order
  int          stamp_q [$];       // cyc minus stalls at acceptance
  logic        hold_check = 1'b0; // previous edge was stalled
  logic        prev_write;
  logic [31:0] prev_data;

  coproc_top coproc_top_inst (
    .CLOCK_50         (CLOCK_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .in_readdata      (in_readdata),
    .in_waitrequest   (in_waitrequest),
    .in_read          (in_read),
    .out_writedata    (out_writedata),
    .out_write        (out_write),
    .out_waitrequest  (out_waitrequest),
    .reset_req        (reset_req),
    .cold_reset       (cold_reset),
    .warm_reset       (warm_reset),
    .debug_reset      (debug_reset),
    .status_count     (status_count),
    .ledr             (ledr)
  );

  always #10 CLOCK_50 = ~CLOCK_50;   // 20 unit period

  // ========================================
  // helpers
  // ========================================
  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("mismatch at %0t: %s expected %0h got %0h", $time, name, exp, act);
    errors++;
  endtask

  // low half times high half, both unsigned
  function automatic logic [31:0] product_of_halves(input logic [31:0] word);
    return {16'd0, word[15:0]} * {16'd0, word[31:16]};
  endfunction

  task automatic end_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - err_before);
    end
  endtask

  // ========================================
  // scoreboard and stall monitor
  // ========================================
  always @(posedge CLOCK_50) begin : monitor
    logic [31:0] exp_p;
    int          stamp;
    int          lat;
    if (hps_fpga_reset_n) begin
      if (hold_check) begin   // stalled last edge, port must hold
        if (out_write !== prev_write) report_mismatch("out_write", prev_write, out_write);
        if (out_writedata !== prev_data) report_mismatch("out_writedata", prev_data, out_writedata);
      end
      if (out_waitrequest && in_read !== 1'b0) report_mismatch("in_read", 32'd0, in_read);
      // delivery first, so a same edge accept never pairs with itself
      if (out_write === 1'b1 && out_waitrequest === 1'b0) begin
        if (exp_q.size() == 0) begin
          $display("error at %0t: product delivered with no word outstanding", $time);
          errors++;
        end else begin
          exp_p = exp_q.pop_front();
          stamp = stamp_q.pop_front();
          lat   = cyc - stall_total - stamp;   // stalled edges removed
          if (out_writedata !== exp_p) report_mismatch("out_writedata", exp_p, out_writedata);
          if (lat != latency) report_mismatch("product latency", latency, lat);
        end
        delivered <= delivered + 1;
      end
      if (in_read === 1'b1) begin
        exp_q.push_back(product_of_halves(in_readdata));
        stamp_q.push_back(cyc - stall_total);
        accepted <= accepted + 1;
      end
      if (out_waitrequest) stall_total <= stall_total + 1;
      hold_check = out_waitrequest;
      prev_write = out_write;
      prev_data  = out_writedata;
    end
    cyc <= cyc + 1;
  end

  always @(posedge CLOCK_50) begin
    if (cyc >= timeout_cycles) begin
      $display("timeout: tests still running after %0d cycles", cyc);
      $display("TB FAILED");
      $finish;
    end
  end

  // ========================================
  // tests
  // ========================================
  task automatic check_idle_outputs();
    if (in_read !== 1'b0) report_mismatch("in_read", 32'd0, in_read);
    if (out_write !== 1'b0) report_mismatch("out_write", 32'd0, out_write);
    if ({debug_reset, warm_reset, cold_reset} !== 3'b000)
      report_mismatch("reset pulses", 32'd0, {debug_reset, warm_reset, cold_reset});
    if (status_count !== 32'd0) report_mismatch("status_count", 32'd0, status_count);
    if (ledr !== 10'd0) report_mismatch("ledr", 32'd0, ledr);
  endtask

  task automatic test_reset_state();
    int err0;
    err0 = errors;
    for (int i = 0; i < 5; i++) begin
      @(posedge CLOCK_50);
      check_idle_outputs();
      if (i == 4) hps_fpga_reset_n <= 1'b1;   // release after 5 cycles
    end
    @(posedge CLOCK_50);   // first edge after release
    check_idle_outputs();
    rel_cyc = cyc;
    end_test("reset state", err0);
  endtask

  task automatic send_single(input logic [31:0] word);
    int target;
    int n;
    target = delivered + 1;
    @(posedge CLOCK_50);
    in_readdata    <= word;
    in_waitrequest <= 1'b0;
    @(posedge CLOCK_50);   // taken on this edge
    in_waitrequest <= 1'b1;
    n = 0;
    while (delivered != target && n < 10) begin
      @(posedge CLOCK_50);
      n++;
    end
    if (delivered != target) begin
      $display("error at %0t: no product for word %0h", $time, word);
      errors++;
    end
  endtask

  task automatic test_single_products();
    int err0;
    err0 = errors;
    send_single(32'h1234_0000);   // 0 times x
    send_single(32'hbeef_0001);   // 1 times x
    send_single(32'hffff_ffff);   // largest product
    send_single(32'h5a01_00c3);   // distinct halves
    end_test("single products", err0);
  endtask

  // random in_waitrequest, optional out_waitrequest stretches
  task automatic stream_words(input string name, input int n_words, input bit use_bp);
    int   err0;
    int   sent;
    int   acc0;
    int   del0;
    int   bp_left;
    int   n;
    logic wr;
    logic bp;
    err0    = errors;
    acc0    = accepted;
    del0    = delivered;
    sent    = 0;
    bp_left = 0;
    while (sent < n_words) begin
      @(posedge CLOCK_50);
      wr = $urandom % 2;
      bp = 1'b0;
      if (use_bp) begin
        if (bp_left > 0) begin
          bp = 1'b1;
          bp_left--;
        end else if ($urandom % 6 == 0) begin
          bp      = 1'b1;
          bp_left = $urandom % 8;   // stretch of 1 to 8 cycles
        end
      end
      in_readdata     <= $urandom;
      in_waitrequest  <= wr;
      out_waitrequest <= bp;
      if (!wr && !bp) sent++;   // taken on next edge
    end
    @(posedge CLOCK_50);
    in_waitrequest  <= 1'b1;
    out_waitrequest <= 1'b0;
    n = 0;
    while (delivered - del0 < n_words && n < 20) begin
      @(posedge CLOCK_50);
      n++;
    end
    repeat (5) @(posedge CLOCK_50);   // catch extra products
    if (accepted - acc0 != n_words) report_mismatch("accepted words", n_words, accepted - acc0);
    if (delivered - del0 != n_words)
      report_mismatch("delivered products", n_words, delivered - del0);
    end_test(name, err0);
  endtask

  task automatic check_pulse(input int idx, input int width, input bit retrigger,
                             input string name);
    logic [2:0] exp_v;
    @(posedge CLOCK_50);
    reset_req[idx] <= 1'b1;
    for (int n = 1; n <= width + 4; n++) begin
      @(posedge CLOCK_50);
      exp_v = (n >= 3 && n <= width + 2) ? (3'b001 << idx) : 3'b000;
      if ({debug_reset, warm_reset, cold_reset} !== exp_v)
        report_mismatch(name, exp_v, {debug_reset, warm_reset, cold_reset});
      if (retrigger && n == 5) reset_req[idx] <= 1'b0;
      if (retrigger && n == 8) reset_req[idx] <= 1'b1;   // edge inside pulse
    end
    reset_req[idx] <= 1'b0;
    repeat (3) @(posedge CLOCK_50);
  endtask

  task automatic test_reset_pulses();
    int err0;
    err0 = errors;
    check_pulse(0, 6, 1'b0, "cold_reset");
    check_pulse(1, 2, 1'b0, "warm_reset");
    check_pulse(2, 32, 1'b1, "debug_reset");
    end_test("reset request pulses", err0);
  endtask

  task automatic test_uptime();
    int          err0;
    logic [31:0] exp_c;
    logic [31:0] prev_c;
    err0 = errors;
    for (int i = 0; i < 100; i++) begin
      @(posedge CLOCK_50);
      exp_c = cyc - rel_cyc;   // edges since release
      if (status_count !== exp_c) report_mismatch("status_count", exp_c, status_count);
      if (i > 0 && status_count !== prev_c + 1)
        report_mismatch("status_count step", prev_c + 1, status_count);
      if (ledr !== exp_c[31:22]) report_mismatch("ledr", exp_c[31:22], ledr);
      prev_c = status_count;
    end
    end_test("uptime counter", err0);
  endtask

  // ========================================
  // run
  // ========================================
  initial begin
    void'($urandom(66));
    hps_fpga_reset_n = 1'b0;
    in_readdata      = 32'd0;
    in_waitrequest   = 1'b1;   // fifo empty
    out_waitrequest  = 1'b0;
    reset_req        = 3'b000;
    test_reset_state();
    test_single_products();
    stream_words("streaming", 200, 1'b0);
    stream_words("back-pressure", 150, 1'b1);
    test_reset_pulses();
    test_uptime();
    $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- build.f
src/coproc_pkg.sv
src/pulse_timer.sv
src/reset_req_fsm.sv
src/mult_pipe.sv
src/coproc_top.sv
tests/coproc_tb.sv
